// File: design/nes_pkg.sv
package nes_pkg;

  // one pad, bit order as the console reads it (a shifts out first)
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_buttons_t;

  // four players, p1 in the low byte
  typedef struct packed {
    pad_buttons_t p4;
    pad_buttons_t p3;
    pad_buttons_t p2;
    pad_buttons_t p1;
  } pad_set_t;

  // mapper flag word as produced by the loader
  typedef logic [63:0] cart_flags_t;

  // battery backed ram present
  localparam int FLAG_HAS_SAVE = 25;

  // core held in reset this many loader-idle cycles after a download
  localparam logic [7:0] DOWNLOAD_SETTLE_CYCLES = 8'd255;

  // four score style adapter signatures, one per port
  localparam logic [7:0] TAP_SIG_PORT1 = 8'h08;
  localparam logic [7:0] TAP_SIG_PORT2 = 8'h04;

  // length of one port's shift register: pad, tap pad, signature
  localparam int JOY_BITS = 24;

  // reset and load sequencer
  typedef enum logic [1:0] {
    boot_wait,
    downloading,
    settling,
    running
  } load_state_t;

endpackage

// File: design/mem_pkg.sv
package mem_pkg;

  // full byte address of the sdram
  localparam int SDRAM_ADDR_W = 25;

  // ppu side address, zero-extended onto channel 0
  localparam int PPU_ADDR_W = 22;

  // save buffer byte address from the platform
  localparam int SAVE_ADDR_W = 18;

  // upper address bits of the save area in sdram
  localparam logic [SDRAM_ADDR_W-SAVE_ADDR_W-1:0] SAVE_REGION = 7'b0001111;

  // one request on an sdram channel
  // wr and rd are strobes, the controller only acts on their rising edge
  typedef struct packed {
    logic [SDRAM_ADDR_W-1:0] addr;
    logic [7:0]              din;
    logic                    wr;
    logic                    rd;
  } mem_req_t;

endpackage

// File: design/joypad_serializer.sv
`timescale 1ns/1ps

module joypad_serializer #(
  parameter logic [$bits(nes_pkg::pad_buttons_t)-1:0] TAP_SIG = 8'hff
) (
  input  logic                 clk_ppu_21_47,
  input  logic                 reset_nes,
  input  logic                 strobe,
  input  logic                 ser_clock,
  input  nes_pkg::pad_buttons_t main_pad,
  input  nes_pkg::pad_buttons_t tap_pad,
  input  logic                 multitap_enabled,
  output logic                 ser_data
);

  import nes_pkg::*;

  localparam int PAD_W = $bits(pad_buttons_t);
  localparam int UPPER_W = JOY_BITS - PAD_W;

  logic [JOY_BITS-1:0] shift_q;
  logic [UPPER_W-1:0]  upper_bits;
  logic [JOY_BITS-1:0] load_word;
  logic                ser_clock_q;
  logic                ser_fall;

  // without the adapter the console reads ones past the first byte
  always_comb begin
    if (multitap_enabled) begin
      upper_bits = {TAP_SIG, tap_pad};
    end else begin
      upper_bits = '1;
    end
  end

  assign load_word = {upper_bits, main_pad};

  // falling edge of the console's clock line
  assign ser_fall = ser_clock_q & ~ser_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      shift_q     <= '0;
      ser_clock_q <= 1'b0;
    end else begin
      ser_clock_q <= ser_clock;
      // shift takes priority over a load in the same cycle
      if (ser_fall) begin
        shift_q <= {1'b0, shift_q[JOY_BITS-1:1]};
      end else if (strobe) begin
        shift_q <= load_word;
      end
    end
  end

  assign ser_data = shift_q[0];

  // pad inputs come from another clock domain on the platform,
  // an X here would reach the cpu bus directly
  a_shift_known: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    !$isunknown(shift_q)
  ) else $error("joypad shift register unknown");

endmodule

// File: design/cart_load_control.sv
`timescale 1ns/1ps

module cart_load_control (
  input  logic                 clk_ppu_21_47,
  input  logic                 reset_nes,
  input  logic                 downloading,
  input  logic                 loader_busy,
  input  logic                 loader_done,
  input  logic                 loader_fail,
  input  nes_pkg::cart_flags_t loader_flags,
  input  logic                 hold_reset,
  output logic                 core_reset,
  output logic                 loader_reset,
  output nes_pkg::cart_flags_t core_flags,
  output logic                 has_save
);

  import nes_pkg::*;

  load_state_t state_q;
  logic [$bits(DOWNLOAD_SETTLE_CYCLES)-1:0] settle_cnt;
  logic        downloading_q;
  cart_flags_t flags_q;

  // the state literal shares its name with the port
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state_q       <= boot_wait;
      settle_cnt    <= '0;
      downloading_q <= 1'b0;
      loader_reset  <= 1'b1;
    end else begin
      downloading_q <= downloading;
      // loader runs only while the settle count is live,
      // plus a kick on every download start
      loader_reset  <= (settle_cnt == '0) || (downloading && !downloading_q);
      if (downloading) begin
        state_q    <= nes_pkg::downloading;
        settle_cnt <= DOWNLOAD_SETTLE_CYCLES;
      end else begin
        case (state_q)
          nes_pkg::downloading: begin
            state_q <= settling;
          end
          settling: begin
            // loader may still be flushing writes, wait it out
            if (!loader_busy) begin
              settle_cnt <= settle_cnt - 1'b1;
              if (settle_cnt == 1) begin
                state_q <= running;
              end
            end
          end
          default: begin
            state_q <= state_q;
          end
        endcase
      end
    end
  end

  // cartridge flags, taken once the header is parsed
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      flags_q <= '0;
    end else if (loader_done) begin
      flags_q <= loader_flags;
    end
  end

  assign core_reset = (state_q != running) || loader_fail || hold_reset || reset_nes;

  // core sees no mapper while a new image is streaming in
  assign core_flags = downloading ? '0 : flags_q;
  assign has_save   = flags_q[FLAG_HAS_SAVE];

  // core stays in reset while the settle count is live
  a_reset_while_settling: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    (settle_cnt != '0) |-> core_reset
  ) else $error("core left reset while settle count still live");

endmodule

// File: design/sdram_port_arbiter.sv
`timescale 1ns/1ps

module sdram_port_arbiter (
  input  logic                            downloading,
  input  logic                            loader_busy,
  input  mem_pkg::mem_req_t               loader_req,
  input  mem_pkg::mem_req_t               ppu_req,
  input  logic                            sleep_savestate,
  input  mem_pkg::mem_req_t               ss_req,
  input  logic                            sd_buff_wr,
  input  logic                            sd_buff_rd,
  input  logic [mem_pkg::SAVE_ADDR_W-1:0] sd_buff_addr,
  input  logic [7:0]                      sd_buff_dout,
  input  logic                            save_busy,
  input  logic [7:0]                      save_dout,
  input  logic [7:0]                      eeprom_dout,
  input  logic                            bram_en,
  output mem_pkg::mem_req_t               ch0_req,
  output mem_pkg::mem_req_t               ch2_req,
  output logic [7:0]                      sd_buff_din
);

  import mem_pkg::*;

  logic     loading;
  mem_req_t save_req;

  assign loading = downloading | loader_busy;

  // channel 0: loader owns it while an image is written
  always_comb begin
    if (loading) begin
      ch0_req.addr = loader_req.addr;
      ch0_req.din  = loader_req.din;
    end else begin
      ch0_req.addr = {{(SDRAM_ADDR_W-PPU_ADDR_W){1'b0}}, ppu_req.addr[PPU_ADDR_W-1:0]};
      ch0_req.din  = ppu_req.din;
    end
    ch0_req.wr = loader_req.wr | ppu_req.wr;
    ch0_req.rd = ~loading & ppu_req.rd;
  end

  // controller only catches a strobe edge on a non-busy cycle
  always_comb begin
    save_req.addr = {SAVE_REGION, sd_buff_addr};
    save_req.din  = sd_buff_dout;
    save_req.wr   = sd_buff_wr & ~save_busy;
    save_req.rd   = sd_buff_rd & ~save_busy;
  end

  // channel 2: save states take over while the core sleeps
  assign ch2_req = sleep_savestate ? ss_req : save_req;

  // mappers with eeprom keep their save in block ram
  assign sd_buff_din = bram_en ? eeprom_dout : save_dout;

  // the loader only writes, a read from it would be dropped here
  always_comb begin
    a_ch0_no_loader_rd: assert final (!(loading && loader_req.rd))
      else $error("loader read request on channel 0 while loading");
  end

endmodule

// File: design/nes_glue_top.sv
`timescale 1ns/1ps

module nes_glue_top (
  input  logic                            clk_ppu_21_47,
  input  logic                            reset_nes,
  input  logic                            downloading,
  input  logic                            loader_busy,
  input  logic                            loader_done,
  input  logic                            loader_fail,
  input  nes_pkg::cart_flags_t            loader_flags,
  input  logic                            hold_reset,
  input  nes_pkg::pad_set_t               pads,
  input  logic                            multitap_enabled,
  input  logic                            joy_strobe,
  input  logic [1:0]                      joy_clock,
  input  logic                            sleep_savestate,
  input  mem_pkg::mem_req_t               loader_req,
  input  mem_pkg::mem_req_t               ppu_req,
  input  mem_pkg::mem_req_t               ss_req,
  input  logic                            sd_buff_wr,
  input  logic                            sd_buff_rd,
  input  logic [mem_pkg::SAVE_ADDR_W-1:0] sd_buff_addr,
  input  logic [7:0]                      sd_buff_dout,
  input  logic                            save_busy,
  input  logic [7:0]                      save_dout,
  input  logic [7:0]                      eeprom_dout,
  input  logic                            bram_en,
  output logic                            core_reset,
  output logic                            loader_reset,
  output nes_pkg::cart_flags_t            core_flags,
  output logic                            has_save,
  output logic [4:0]                      joypad1_data,
  output logic [4:0]                      joypad2_data,
  output mem_pkg::mem_req_t               ch0_req,
  output mem_pkg::mem_req_t               ch2_req,
  output logic [7:0]                      sd_buff_din
);

  import nes_pkg::*;

  logic port1_bit;
  logic port2_bit;

  cart_load_control i_cart_load_control (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .downloading   (downloading),
    .loader_busy   (loader_busy),
    .loader_done   (loader_done),
    .loader_fail   (loader_fail),
    .loader_flags  (loader_flags),
    .hold_reset    (hold_reset),
    .core_reset    (core_reset),
    .loader_reset  (loader_reset),
    .core_flags    (core_flags),
    .has_save      (has_save)
  );

  // port 1 carries players 1 and 3
  joypad_serializer #(
    .TAP_SIG (TAP_SIG_PORT1)
  ) port1 (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .strobe           (joy_strobe),
    .ser_clock        (joy_clock[0]),
    .main_pad         (pads.p1),
    .tap_pad          (pads.p3),
    .multitap_enabled (multitap_enabled),
    .ser_data         (port1_bit)
  );

  // port 2 carries players 2 and 4
  joypad_serializer #(
    .TAP_SIG (TAP_SIG_PORT2)
  ) port2 (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .strobe           (joy_strobe),
    .ser_clock        (joy_clock[1]),
    .main_pad         (pads.p2),
    .tap_pad          (pads.p4),
    .multitap_enabled (multitap_enabled),
    .ser_data         (port2_bit)
  );

  // mic, paddle, light gun trigger and light bits are not fitted
  assign joypad1_data = {4'b0000, port1_bit};
  assign joypad2_data = {4'b0000, port2_bit};

  sdram_port_arbiter i_sdram_port_arbiter (
    .downloading     (downloading),
    .loader_busy     (loader_busy),
    .loader_req      (loader_req),
    .ppu_req         (ppu_req),
    .sleep_savestate (sleep_savestate),
    .ss_req          (ss_req),
    .sd_buff_wr      (sd_buff_wr),
    .sd_buff_rd      (sd_buff_rd),
    .sd_buff_addr    (sd_buff_addr),
    .sd_buff_dout    (sd_buff_dout),
    .save_busy       (save_busy),
    .save_dout       (save_dout),
    .eeprom_dout     (eeprom_dout),
    .bram_en         (bram_en),
    .ch0_req         (ch0_req),
    .ch2_req         (ch2_req),
    .sd_buff_din     (sd_buff_din)
  );

endmodule

// File: test/tb_nes_glue.sv
`timescale 1ns/1ps

module tb_nes_glue;

  import nes_pkg::*;
  import mem_pkg::*;

  localparam logic [2:0] OP_BOOT  = 3'd0;
  localparam logic [2:0] OP_LOAD  = 3'd1;
  localparam logic [2:0] OP_PADS  = 3'd2;
  localparam logic [2:0] OP_ROUTE = 3'd3;
  localparam logic [2:0] OP_PULSE = 3'd4;
  localparam int NUM_TESTS = 10;

  // one row of the stimulus table
  typedef struct packed {
    logic [2:0]          op;
    pad_set_t            pads;
    logic                multitap;
    logic [7:0]          busy_cycles;
    logic [9:0]          exp_edges;
    logic [JOY_BITS-1:0] exp_port1;
    logic [JOY_BITS-1:0] exp_port2;
  } test_entry_t;

  logic                   clk_ppu_21_47;
  logic                   reset_nes;
  logic                   downloading;
  logic                   loader_busy;
  logic                   loader_done;
  logic                   loader_fail;
  cart_flags_t            loader_flags;
  logic                   hold_reset;
  pad_set_t               pads;
  logic                   multitap_enabled;
  logic                   joy_strobe;
  logic [1:0]             joy_clock;
  logic                   sleep_savestate;
  mem_req_t               loader_req;
  mem_req_t               ppu_req;
  mem_req_t               ss_req;
  logic                   sd_buff_wr;
  logic                   sd_buff_rd;
  logic [SAVE_ADDR_W-1:0] sd_buff_addr;
  logic [7:0]             sd_buff_dout;
  logic                   save_busy;
  logic [7:0]             save_dout;
  logic [7:0]             eeprom_dout;
  logic                   bram_en;
  logic                   core_reset;
  logic                   loader_reset;
  cart_flags_t            core_flags;
  logic                   has_save;
  logic [4:0]             joypad1_data;
  logic [4:0]             joypad2_data;
  mem_req_t               ch0_req;
  mem_req_t               ch2_req;
  logic [7:0]             sd_buff_din;

  test_entry_t tests [NUM_TESTS];
  integer      seed;
  int          fill_idx;
  int          budget;
  int          cycle_count;
  int          cycle_limit;
  int          checks;
  int          errors;
  int          failed_tests;

  nes_glue_top i_dut (.*);

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #10 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  // run guard, limit set once the table is built
  always @(posedge clk_ppu_21_47) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: no result after %0d clock cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk_ppu_21_47);
    #2;
  endtask

  task automatic check(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("[FAIL] %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  // serial word as the console reads it, lsb first
  function automatic logic [JOY_BITS-1:0] expected_word(input pad_buttons_t main_pad,
                                                       input pad_buttons_t tap_pad,
                                                       input logic mt, input logic [7:0] sig);
    logic [15:0] upper;
    upper = mt ? {sig, tap_pad} : 16'hffff;
    return {upper, main_pad};
  endfunction

  function automatic string op_name(input logic [2:0] op);
    case (op)
      OP_BOOT:  return "boot";
      OP_LOAD:  return "load";
      OP_PADS:  return "pads";
      OP_ROUTE: return "route";
      default:  return "reset pulses";
    endcase
  endfunction

  task automatic add_entry(input logic [2:0] op, input logic mt, input logic [7:0] busy);
    test_entry_t e;
    e.op          = op;
    e.pads        = $random(seed);
    e.multitap    = mt;
    e.busy_cycles = busy;
    // one edge to reach settling, then the count, plus the stalled edges
    e.exp_edges   = 10'(DOWNLOAD_SETTLE_CYCLES) + 10'd1 + 10'(busy);
    e.exp_port1   = expected_word(e.pads.p1, e.pads.p3, mt, TAP_SIG_PORT1);
    e.exp_port2   = expected_word(e.pads.p2, e.pads.p4, mt, TAP_SIG_PORT2);
    tests[fill_idx] = e;
    fill_idx++;
    case (op)
      OP_LOAD:  budget += int'(DOWNLOAD_SETTLE_CYCLES) + int'(busy) + 16;
      OP_PADS:  budget += 2 * (JOY_BITS + 4) + 4;
      OP_ROUTE: budget += 20;
      default:  budget += 8;
    endcase
  endtask

  task automatic build_table();
    budget = 16;
    add_entry(OP_BOOT, 1'b0, 8'd0);
    add_entry(OP_LOAD, 1'b0, 8'd0);
    add_entry(OP_PADS, 1'b0, 8'd0);
    add_entry(OP_PADS, 1'b1, 8'd0);
    add_entry(OP_ROUTE, 1'b0, 8'd0);
    add_entry(OP_PULSE, 1'b0, 8'd0);
    add_entry(OP_LOAD, 1'b0, 8'd9);
    add_entry(OP_PADS, 1'b1, 8'd0);
    add_entry(OP_PADS, 1'b0, 8'd0);
    add_entry(OP_ROUTE, 1'b0, 8'd0);
    cycle_limit = 2 * budget;
  endtask

  task automatic check_boot_state();
    repeat (4) begin
      check(core_reset === 1'b1, "core_reset low before first download");
      check(loader_reset === 1'b1, "loader_reset low before first download");
      check(core_flags === '0, "core_flags not zero after reset");
      step();
    end
  endtask

  task automatic load_cartridge(input test_entry_t e);
    cart_flags_t flags;
    int n;
    flags = {$random(seed), $random(seed)};
    downloading = 1'b1;
    step();
    check(loader_reset === 1'b1, "loader_reset low after download start");
    repeat (4) step();
    // settle count is live now, the loader runs
    check(loader_reset === 1'b0, "loader_reset stuck high while downloading");
    loader_done  = 1'b1;
    loader_flags = flags;
    step();
    loader_done  = 1'b0;
    loader_flags = ~flags;
    check(has_save === flags[FLAG_HAS_SAVE], "has_save does not follow flag bit 25");
    check(core_flags === '0, "core_flags not zero while downloading");
    step();
    check(core_reset === 1'b1, "core_reset low while downloading");
    downloading = 1'b0;
    #1;
    check(core_flags === flags,
          $sformatf("core_flags %h, expected %h", core_flags, flags));
    n = 0;
    while (core_reset === 1'b1 && n < 1000) begin
      // stall the count somewhere inside the settling window
      loader_busy = (n >= 8 && n < 8 + int'(e.busy_cycles));
      step();
      n++;
    end
    loader_busy = 1'b0;
    check(n == int'(e.exp_edges),
          $sformatf("core_reset dropped after %0d edges, expected %0d", n, e.exp_edges));
  endtask

  task automatic read_pads(input test_entry_t e);
    logic exp1;
    logic exp2;
    pads             = e.pads;
    multitap_enabled = e.multitap;
    joy_strobe       = 1'b1;
    step();
    joy_strobe = 1'b0;
    for (int k = 0; k < JOY_BITS + 4; k++) begin
      exp1 = (k < JOY_BITS) ? e.exp_port1[k] : 1'b0;
      exp2 = (k < JOY_BITS) ? e.exp_port2[k] : 1'b0;
      check(joypad1_data === {4'b0000, exp1},
            $sformatf("port 1 bit %0d is %b, expected %b", k, joypad1_data, exp1));
      check(joypad2_data === {4'b0000, exp2},
            $sformatf("port 2 bit %0d is %b, expected %b", k, joypad2_data, exp2));
      joy_clock = 2'b11;
      step();
      joy_clock = 2'b00;
      step();
    end
  endtask

  task automatic sweep_routing();
    logic [63:0] ra;
    logic [63:0] rb;
    logic [63:0] rc;
    logic        loading;
    mem_req_t    exp0;
    mem_req_t    exp2;
    for (int c = 0; c < 16; c++) begin
      ra = {$random(seed), $random(seed)};
      rb = {$random(seed), $random(seed)};
      rc = {$random(seed), $random(seed)};
      loader_busy     = c[0];
      save_busy       = c[1];
      sleep_savestate = c[2];
      bram_en         = c[3];
      loader_req      = ra[34:0];
      // the loader only ever writes
      loader_req.rd   = 1'b0;
      save_dout       = ra[42:35];
      eeprom_dout     = ra[50:43];
      ppu_req         = rb[34:0];
      sd_buff_addr    = rb[52:35];
      sd_buff_wr      = rb[53];
      sd_buff_rd      = rb[54];
      ss_req          = rc[34:0];
      sd_buff_dout    = rc[42:35];
      #1;
      loading   = downloading | loader_busy;
      exp0.addr = loading ? loader_req.addr : SDRAM_ADDR_W'(ppu_req.addr[PPU_ADDR_W-1:0]);
      exp0.din  = loading ? loader_req.din : ppu_req.din;
      exp0.wr   = loader_req.wr | ppu_req.wr;
      exp0.rd   = ~loading & ppu_req.rd;
      if (sleep_savestate) begin
        exp2 = ss_req;
      end else begin
        exp2.addr = {SAVE_REGION, sd_buff_addr};
        exp2.din  = sd_buff_dout;
        exp2.wr   = sd_buff_wr & ~save_busy;
        exp2.rd   = sd_buff_rd & ~save_busy;
      end
      check(ch0_req === exp0, $sformatf("case %0d ch0 %h, expected %h", c, ch0_req, exp0));
      check(ch2_req === exp2, $sformatf("case %0d ch2 %h, expected %h", c, ch2_req, exp2));
      check(sd_buff_din === (bram_en ? eeprom_dout : save_dout),
            $sformatf("case %0d sd_buff_din %h with bram_en %b", c, sd_buff_din, bram_en));
      step();
    end
    loader_busy     = 1'b0;
    save_busy       = 1'b0;
    sleep_savestate = 1'b0;
    bram_en         = 1'b0;
  endtask

  task automatic pulse_resets();
    check(core_reset === 1'b0, "core_reset high although running");
    hold_reset = 1'b1;
    #1;
    check(core_reset === 1'b1, "core_reset ignores hold_reset");
    step();
    hold_reset = 1'b0;
    #1;
    check(core_reset === 1'b0, "core_reset stuck after hold_reset");
    loader_fail = 1'b1;
    #1;
    check(core_reset === 1'b1, "core_reset ignores loader_fail");
    step();
    loader_fail = 1'b0;
    #1;
    check(core_reset === 1'b0, "core_reset stuck after loader_fail");
    reset_nes = 1'b1;
    #1;
    check(core_reset === 1'b1, "core_reset ignores reset_nes");
    step();
    reset_nes = 1'b0;
    // back in boot, held until the next download
    check(core_reset === 1'b1 && loader_reset === 1'b1, "resets low after reset_nes pulse");
    step();
    check(core_reset === 1'b1, "core_reset released without a download");
  endtask

  initial begin
    int errs_before;
    seed             = 32'hd19040e2;
    reset_nes        = 1'b1;
    downloading      = 1'b0;
    loader_busy      = 1'b0;
    loader_done      = 1'b0;
    loader_fail      = 1'b0;
    loader_flags     = '0;
    hold_reset       = 1'b0;
    pads             = '0;
    multitap_enabled = 1'b0;
    joy_strobe       = 1'b0;
    joy_clock        = 2'b00;
    sleep_savestate  = 1'b0;
    loader_req       = '0;
    ppu_req          = '0;
    ss_req           = '0;
    sd_buff_wr       = 1'b0;
    sd_buff_rd       = 1'b0;
    sd_buff_addr     = '0;
    sd_buff_dout     = '0;
    save_busy        = 1'b0;
    save_dout        = '0;
    eeprom_dout      = '0;
    bram_en          = 1'b0;
    build_table();
    repeat (16) @(posedge clk_ppu_21_47);
    #2;
    reset_nes = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      errs_before = errors;
      case (tests[i].op)
        OP_BOOT:  check_boot_state();
        OP_LOAD:  load_cartridge(tests[i]);
        OP_PADS:  read_pads(tests[i]);
        OP_ROUTE: sweep_routing();
        default:  pulse_resets();
      endcase
      if (errors == errs_before) begin
        $display("test %0d %s: ok", i, op_name(tests[i].op));
      end else begin
        failed_tests++;
        $display("test %0d %s: %0d mismatches", i, op_name(tests[i].op), errors - errs_before);
      end
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             NUM_TESTS, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
design/nes_pkg.sv
design/mem_pkg.sv
design/joypad_serializer.sv
design/cart_load_control.sv
design/sdram_port_arbiter.sv
design/nes_glue_top.sv
test/tb_nes_glue.sv

// File: Makefile
# Verilator build and run for the NES glue testbench

VERILATOR ?= verilator
TOP       ?= tb_nes_glue
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
